// ==== common/conv_config.svh ====
// conv engine configuration
// pixel and accumulator widths, window length and FIFO sizing

`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// pixel and weight width
`define CONV_PIX_W 16

// window length in pixels
`define CONV_TAPS 3

// fraction bits dropped after accumulation
`define CONV_QF 8

// entries per stream FIFO
`define CONV_FIFO_DEPTH 4

// full product plus two guard bits
`define CONV_ACC_W 34

`endif

// ==== common/conv_pkg.sv ====
// conv engine types
// pixel, weight, window, result and configuration structs

`include "conv_config.svh"

package conv_pkg;

   // one signed sample
   typedef logic signed [`CONV_PIX_W-1:0] pixel_t;

   // one signed coefficient
   typedef logic signed [`CONV_PIX_W-1:0] weight_t;

   // sliding window, pix[0] is the oldest pixel
   typedef struct packed {
      pixel_t [`CONV_TAPS-1:0] pix;
      logic                    last;  // final window of the line
   } window_t;

   // one output sample
   typedef struct packed {
      pixel_t pix;
      logic   last;
   } result_t;

   // static run configuration
   typedef struct packed {
      weight_t [`CONV_TAPS-1:0] weight;  // weight[i] scales pix[i]
      pixel_t                   bias;
      logic                     relu_en;
   } conv_cfg_t;

endpackage

// ==== logic/stream_fifo.sv ====
// small valid/ready FIFO
// circular buffer with read/write pointers and an entry count,
// payload type set per instance

`timescale 1ns/10ps

`include "conv_config.svh"

module stream_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = `CONV_FIFO_DEPTH
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     push_valid_i,
   output logic     push_ready_o,
   input  payload_t push_data_i,
   output logic     pop_valid_o,
   input  logic     pop_ready_i,
   output payload_t pop_data_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
   localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

   payload_t          mem_q [DEPTH];
   logic [PTR_W-1:0]  wr_ptr_q;
   logic [PTR_W-1:0]  rd_ptr_q;
   logic [CNT_W-1:0]  count_q;
   logic              push;
   logic              pop;

   // a full FIFO still takes data when it is being drained
   assign push_ready_o = (count_q != CNT_FULL) || pop_ready_i;
   assign pop_valid_o  = (count_q != '0);
   assign pop_data_o   = mem_q[rd_ptr_q];

   assign push = push_valid_i && push_ready_o;
   assign pop  = pop_valid_o && pop_ready_i;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;  // idle or pass-through
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem_q[wr_ptr_q] <= push_data_i;
      end
   end

endmodule

// ==== conv_engine/conv_window.sv ====
// sliding window generator
// builds CONV_TAPS-pixel windows along each line, restarting at every line end

`timescale 1ns/10ps

`include "conv_config.svh"

module conv_window import conv_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    in_valid_i,
   output logic    in_ready_o,
   input  pixel_t  in_pix_i,
   input  logic    in_last_i,
   output logic    win_valid_o,
   input  logic    win_ready_i,
   output window_t win_o
);

   localparam int FILL_W = $clog2(`CONV_TAPS);
   localparam logic [FILL_W-1:0] FILL_FULL = FILL_W'(`CONV_TAPS - 1);

   pixel_t [`CONV_TAPS-2:0] hist_q;  // hist_q[0] oldest
   logic   [FILL_W-1:0]     fill_q;  // pixels held for the current line
   logic                    win_valid_q;
   window_t                 win_q;
   logic                    pix_take;
   logic                    win_emit;

   // output register free or draining this cycle
   assign in_ready_o = !win_valid_q || win_ready_i;
   assign pix_take   = in_valid_i && in_ready_o;
   assign win_emit   = pix_take && (fill_q == FILL_FULL);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fill_q      <= '0;
         win_valid_q <= 1'b0;
      end else begin
         if (pix_take) begin
            if (in_last_i) begin
               fill_q <= '0;  // next pixel opens a new line
            end else if (fill_q != FILL_FULL) begin
               fill_q <= fill_q + 1'b1;
            end
         end
         if (win_emit) begin
            win_valid_q <= 1'b1;
         end else if (win_ready_i) begin
            win_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pix_take) begin
         hist_q <= {in_pix_i, hist_q[`CONV_TAPS-2:1]};  // shift in newest
      end
      if (win_emit) begin
         win_q.pix  <= {in_pix_i, hist_q};  // newest pixel on top
         win_q.last <= in_last_i;
      end
   end

   assign win_valid_o = win_valid_q;
   assign win_o       = win_q;

endmodule

// ==== conv_engine/conv_mac.sv ====
// sum-of-products stage
// stage one multiplies the window by the weights, stage two accumulates,
// normalizes, adds bias, saturates and optionally rectifies

`timescale 1ns/10ps

`include "conv_config.svh"

module conv_mac import conv_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  conv_cfg_t cfg_i,
   input  logic      win_valid_i,
   output logic      win_ready_o,
   input  window_t   win_i,
   output logic      res_valid_o,
   input  logic      res_ready_i,
   output result_t   res_o
);

   localparam int PROD_W = 2 * `CONV_PIX_W;
   localparam int ACC_W  = `CONV_ACC_W;
   localparam logic signed [ACC_W-1:0] SAT_MAX = (2 ** (`CONV_PIX_W - 1)) - 1;
   localparam logic signed [ACC_W-1:0] SAT_MIN = -(2 ** (`CONV_PIX_W - 1));

   logic                     advance;
   logic                     s1_valid_q;
   logic signed [PROD_W-1:0] prod_q [`CONV_TAPS];
   logic                     s1_last_q;
   logic                     s2_valid_q;
   result_t                  res_q;

   logic signed [ACC_W-1:0]  acc;
   logic signed [ACC_W-1:0]  acc_norm;
   logic signed [ACC_W-1:0]  acc_bias;
   pixel_t                   sat_pix;
   pixel_t                   out_pix;

   // whole pipe moves unless the output is held
   assign advance     = !s2_valid_q || res_ready_i;
   assign win_ready_o = advance;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_valid_q <= 1'b0;
         s2_valid_q <= 1'b0;
      end else if (advance) begin
         s1_valid_q <= win_valid_i;
         s2_valid_q <= s1_valid_q;
      end
   end

   // stage two arithmetic on registered products
   always_comb begin
      acc = '0;
      for (int i = 0; i < `CONV_TAPS; i++) begin
         acc = acc + prod_q[i];  // sign-extended into the guard bits
      end
      acc_norm = acc >>> `CONV_QF;
      acc_bias = acc_norm + cfg_i.bias;
      if (acc_bias > SAT_MAX) begin
         sat_pix = SAT_MAX[`CONV_PIX_W-1:0];
      end else if (acc_bias < SAT_MIN) begin
         sat_pix = SAT_MIN[`CONV_PIX_W-1:0];
      end else begin
         sat_pix = acc_bias[`CONV_PIX_W-1:0];
      end
      // rectifier clamps negatives
      out_pix = (cfg_i.relu_en && sat_pix < 0) ? '0 : sat_pix;
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         for (int i = 0; i < `CONV_TAPS; i++) begin
            prod_q[i] <= $signed(win_i.pix[i]) * $signed(cfg_i.weight[i]);
         end
         s1_last_q  <= win_i.last;
         res_q.pix  <= out_pix;
         res_q.last <= s1_last_q;
      end
   end

   assign res_valid_o = s2_valid_q;
   assign res_o       = res_q;

endmodule

// ==== conv_engine/conv_engine.sv ====
// conv engine top level
// window generator -> window FIFO -> sum-of-products -> result FIFO

`timescale 1ns/10ps

`include "conv_config.svh"

module conv_engine import conv_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  conv_cfg_t cfg_i,
   input  logic      in_valid_i,
   output logic      in_ready_o,
   input  pixel_t    in_pix_i,
   input  logic      in_last_i,
   output logic      out_valid_o,
   input  logic      out_ready_i,
   output result_t   out_res_o
);

   // window generator to window FIFO
   logic    gen_valid;
   logic    gen_ready;
   window_t gen_win;

   // window FIFO to MAC
   logic    mac_in_valid;
   logic    mac_in_ready;
   window_t mac_in_win;

   // MAC to result FIFO
   logic    mac_out_valid;
   logic    mac_out_ready;
   result_t mac_out_res;

   conv_window i_window (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .in_pix_i    (in_pix_i),
      .in_last_i   (in_last_i),
      .win_valid_o (gen_valid),
      .win_ready_i (gen_ready),
      .win_o       (gen_win)
   );

   stream_fifo #(
      .payload_t (window_t),
      .DEPTH     (`CONV_FIFO_DEPTH)
   ) i_win_fifo (
      .clk          (clk),
      .rst_n        (rst_n),
      .push_valid_i (gen_valid),
      .push_ready_o (gen_ready),
      .push_data_i  (gen_win),
      .pop_valid_o  (mac_in_valid),
      .pop_ready_i  (mac_in_ready),
      .pop_data_o   (mac_in_win)
   );

   conv_mac i_mac (
      .clk         (clk),
      .rst_n       (rst_n),
      .cfg_i       (cfg_i),
      .win_valid_i (mac_in_valid),
      .win_ready_o (mac_in_ready),
      .win_i       (mac_in_win),
      .res_valid_o (mac_out_valid),
      .res_ready_i (mac_out_ready),
      .res_o       (mac_out_res)
   );

   stream_fifo #(
      .payload_t (result_t),
      .DEPTH     (`CONV_FIFO_DEPTH)
   ) i_res_fifo (
      .clk          (clk),
      .rst_n        (rst_n),
      .push_valid_i (mac_out_valid),
      .push_ready_o (mac_out_ready),
      .push_data_i  (mac_out_res),
      .pop_valid_o  (out_valid_o),
      .pop_ready_i  (out_ready_i),
      .pop_data_o   (out_res_o)
   );

endmodule

// ==== dv/conv_assertions.sv ====
// stream protocol checks on the conv engine ports
// bound into conv_engine by the testbench

`timescale 1ns/10ps

module conv_assertions import conv_pkg::*; (
   input logic    clk,
   input logic    rst_n,
   input logic    in_valid_i,
   input logic    in_ready_i,
   input pixel_t  in_pix_i,
   input logic    in_last_i,
   input logic    out_valid_i,
   input logic    out_ready_i,
   input result_t out_res_i
);

   int unsigned fail_count = 0;  // read by the testbench at the end

   // nothing leaves the engine while reset is held
   a_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid_i)
      else begin
         fail_count++;
         $error("out_valid_o high during reset");
      end

   // stalled output keeps valid and payload
   a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_res_i))
      else begin
         fail_count++;
         $error("output stream changed while stalled");
      end

   a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
      in_valid_i && !in_ready_i |=> in_valid_i && $stable({in_pix_i, in_last_i}))
      else begin
         fail_count++;
         $error("input pixel changed before it was taken");
      end

endmodule

// ==== dv/conv_tb.sv ====
// testbench for the conv engine
// reads configs, pixel lines and expected results from the tests file,
// drives the input stream and checks outputs under random back-pressure

`timescale 1ns/10ps

`include "conv_config.svh"

module conv_tb import conv_pkg::*; ();

   localparam int MEM_DEPTH = 256;

   logic        clk = 1'b0;
   logic        rst_n;
   conv_cfg_t   cfg_i;
   logic        in_valid_i;
   logic        in_ready_o;
   pixel_t      in_pix_i;
   logic        in_last_i;
   logic        out_valid_o;
   logic        out_ready_i;
   result_t     out_res_o;

   logic [19:0] test_mem [MEM_DEPTH];
   result_t     exp_q [$];    // results still to come, in order
   conv_cfg_t   next_cfg;
   logic [31:0] lfsr_q = 32'd77651;
   int          exp_total = 0;
   int          pixel_total = 0;
   int          recv_count = 0;
   int          check_count = 0;
   int          error_count = 0;
   int          limit_cycles = 0;

   conv_engine i_dut (.*);

   bind conv_engine conv_assertions i_assertions (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid_i  (in_valid_i),
      .in_ready_i  (in_ready_o),
      .in_pix_i    (in_pix_i),
      .in_last_i   (in_last_i),
      .out_valid_i (out_valid_o),
      .out_ready_i (out_ready_i),
      .out_res_i   (out_res_o)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      logic [31:0] shifted;
      shifted = state >> 1;
      if (state[0]) begin
         shifted = shifted ^ 32'hD000_0001;
      end
      return shifted;
   endfunction

   task automatic check_value(input string name, input logic signed [31:0] got,
                              input logic signed [31:0] want);
      check_count++;
      if (got !== want) begin
         error_count++;
         $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, want);
      end
   endtask

   task automatic load_tests();
      logic [19:0] word;
      result_t     want;
      $readmemh("dv/conv_tests.txt", test_mem);
      for (int i = 0; i < MEM_DEPTH; i++) begin
         word = test_mem[i];
         if (word[19:16] == 4'hF) begin
            break;
         end
         case (word[19:16])
            4'h1, 4'h2, 4'h3, 4'h4, 4'h5: ;  // config, applied while driving
            4'h6, 4'h7: pixel_total++;
            4'h8, 4'h9: begin
               want.pix  = word[`CONV_PIX_W-1:0];
               want.last = (word[19:16] == 4'h9);
               exp_q.push_back(want);
            end
            default: begin
               error_count++;
               $display("tests file holds an unknown record %h at entry %0d", word, i);
               break;
            end
         endcase
      end
      exp_total = exp_q.size();
   endtask

   task automatic drive_pixel(input pixel_t pix, input logic last);
      logic taken;
      in_valid_i = 1'b1;
      in_pix_i   = pix;
      in_last_i  = last;
      taken      = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = in_ready_o;  // settled, transfer on the next edge
         @(posedge clk);
         #1;
      end
      in_valid_i = 1'b0;
   endtask

   // returns at 1 ns after an edge once enough results came back
   task automatic wait_drained(input int target);
      while (recv_count < target) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic take_result(input result_t got);
      result_t want;
      if (exp_q.size() == 0) begin
         error_count++;
         $display("output %0d at %0t arrived with no result left to expect", got.pix, $time);
      end else begin
         want = exp_q.pop_front();
         check_value("out_res_o.pix", 32'(got.pix), 32'(want.pix));
         check_value("out_res_o.last", 32'(got.last), 32'(want.last));
      end
      recv_count++;
   endtask

   // random back-pressure, one LFSR bit per cycle
   always @(posedge clk) begin
      #1;
      lfsr_q      = lfsr_next(lfsr_q);
      out_ready_i = lfsr_q[0];
   end

   always @(negedge clk) begin
      if (rst_n && out_valid_o && out_ready_i) begin
         take_result(out_res_o);
      end
   end

   initial begin
      wait (limit_cycles != 0);
      repeat (limit_cycles) @(posedge clk);
      $display("run timed out after %0d cycles with %0d of %0d results seen",
               limit_cycles, recv_count, exp_total);
      $display("Errors found");
      $finish;
   end

   initial begin
      logic [19:0] word;
      int          idx;
      int          exp_seen;
      rst_n       = 1'b0;
      cfg_i       = '0;
      next_cfg    = '0;
      in_valid_i  = 1'b0;
      in_pix_i    = '0;
      in_last_i   = 1'b0;
      out_ready_i = 1'b0;
      load_tests();
      limit_cycles = 40 * pixel_total + 100;
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      check_value("out_valid_o", 32'(out_valid_o), 0);
      check_value("in_ready_o", 32'(in_ready_o), 1);
      @(posedge clk);
      #1;
      idx      = 0;
      exp_seen = 0;
      while (idx < MEM_DEPTH && test_mem[idx][19:16] != 4'hF) begin
         word = test_mem[idx];
         case (word[19:16])
            4'h1: next_cfg.weight[0] = word[`CONV_PIX_W-1:0];
            4'h2: next_cfg.weight[1] = word[`CONV_PIX_W-1:0];
            4'h3: next_cfg.weight[2] = word[`CONV_PIX_W-1:0];
            4'h4: next_cfg.bias      = word[`CONV_PIX_W-1:0];
            4'h5: begin
               next_cfg.relu_en = word[0];
               wait_drained(exp_seen);  // no line in flight when cfg moves
               cfg_i = next_cfg;
            end
            4'h6: drive_pixel(word[`CONV_PIX_W-1:0], 1'b0);
            4'h7: drive_pixel(word[`CONV_PIX_W-1:0], 1'b1);
            4'h8, 4'h9: exp_seen++;
            default: ;
         endcase
         idx++;
      end
      wait_drained(exp_total);
      repeat (20) @(posedge clk);  // room for any extra output
      error_count += i_dut.i_assertions.fail_count;
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+common
common/conv_pkg.sv
logic/stream_fifo.sv
conv_engine/conv_window.sv
conv_engine/conv_mac.sv
conv_engine/conv_engine.sv
dv/conv_assertions.sv
dv/conv_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the conv engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module conv_tb -f files.f -o conv_sim \
   && ./obj_dir/conv_sim +verilator+error+limit+100 > sim.log 2>&1 \
   && cat sim.log \
   && ! grep -q "Errors found" sim.log \
   && echo "PASS" \
   || { cat sim.log 2>/dev/null; echo "FAIL"; exit 1; }

// ==== dv/conv_tests.txt ====
// one 20-bit hex word per entry: tag digit, then a 16-bit value
// tags 1-3 weight0-2, 4 bias, 5 relu flag + apply, 6/7 pixel (7 ends line), 8/9 expected (9 last)
// test 1: fractional weights 0.5 1.0 1.5, bias 5
10080 20100 30180 40005 50000
6000A 60014 6001E 70028 8004B 90069
6FFFF 60000 60000 70001 80004 90006
// test 2: saturation with full-scale weights
17FFF 27FFF 37FFF 40000 50000
67FFF 67FFF 67FFF 68000 68000 78000 87FFF 87FFF 88000 98000
// test 3: rectifier on, unit weights, bias -10
10100 20100 30100 4FFF6 50001
60002 6FFFB 60001 70014 80000 90006
// test 4: same data with the rectifier off
10100 20100 30100 4FFF6 50000
60002 6FFFB 60001 70014 8FFF4 90006
// test 5: line framing, short lines give nothing
70005 60007 70008
60001 60002 70003 9FFFC
6000A 60014 6001E 60028 60032 7003C 80032 80050 8006E 9008C
603E8 707D0 60001 60001 70001 9FFF9
// test 6: long lines, output is the oldest pixel of each window
10100 20000 30000 40000 50000
60001 60002 60003 60004 60005 60006 60007 60008 60009 6000A 6000B 7000C
80001 80002 80003 80004 80005 80006 80007 80008 80009 9000A
60020 60021 60022 60023 60024 70025 80020 80021 80022 90023
F0000
